/* build.f */
+incdir+include
source/boot_pkg.sv
source/mem_req_if.sv
source/flash_reader.sv
source/boot_copier.sv
source/ram_port.sv
source/seg_decoder.sv
source/boot_mem_top.sv
dv/boot_checker.sv
dv/tb_boot_mem.sv

/* dv/boot_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "boot_config.svh"

module boot_checker (
	input  logic                clk,
	input  logic                reset,
	input  logic                boot_done,
	input  logic                ram_en,
	input  logic                ram_oe,
	input  logic                ram_we,
	input  boot_pkg::ram_addr_t ram_addr,
	input  boot_pkg::word_t     ram_wdata,
	input  logic                host_req,
	input  logic                host_we,
	input  boot_pkg::ram_addr_t host_addr,
	input  boot_pkg::word_t     host_wdata,
	input  logic                host_ack,
	input  boot_pkg::word_t     host_rdata,
	input  logic [6:0]          seg_hi,
	input  logic [6:0]          seg_lo,
	output int                  checks,
	output int                  errors,
	output int                  write_errors
);

	// Hex digit patterns with bit 0 as segment a
	localparam logic [6:0] seg_table [16] = '{
		7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
		7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
	};
	localparam int last_word = `BOOT_WORDS - 1;

	int              next_word;
	logic            done_seen;
	logic            ack_seen;
	boot_pkg::word_t written [int];

	function automatic boot_pkg::word_t image_word(input int idx);
		logic [31:0] prod;
		prod = idx * 32'h9e37;
		return prod[15:0] ^ 16'h5a5a;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		errors++;
		$display("mismatch at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
	endtask

	task automatic report_error(input string what);
		errors++;
		$display("error at %0t: %s", $time, what);
	endtask

	always @(posedge clk) begin
		if (reset) begin
			next_word = 0;
			done_seen = 1'b0;
			ack_seen = 1'b0;
			checks = 0;
			errors = 0;
			write_errors = 0;
			written.delete();
		end else begin
			if (ram_we && ram_oe) begin
				report_error("ram_we and ram_oe high together");
			end
			// Boot writes come in address order with one per word
			if (ram_en && ram_we && !boot_done) begin
				checks++;
				if (ram_addr !== boot_pkg::ram_addr_t'(next_word)) begin
					report_mismatch("ram_addr", 32'(next_word), 32'(ram_addr));
					write_errors++;
				end
				if (ram_wdata !== image_word(next_word)) begin
					report_mismatch("ram_wdata", 32'(image_word(next_word)), 32'(ram_wdata));
					write_errors++;
				end
				next_word++;
			end
			if (boot_done && !done_seen) begin
				done_seen = 1'b1;
				checks++;
				if (next_word != `BOOT_WORDS) begin
					report_error($sformatf("boot_done rose after %0d of %0d words",
						next_word, `BOOT_WORDS));
				end
				if (seg_hi !== seg_table[(last_word >> 4) & 15]) begin
					report_mismatch("seg_hi", 32'(seg_table[(last_word >> 4) & 15]), 32'(seg_hi));
				end
				if (seg_lo !== seg_table[last_word & 15]) begin
					report_mismatch("seg_lo", 32'(seg_table[last_word & 15]), 32'(seg_lo));
				end
			end
			if (host_ack && !boot_done) begin
				report_error("host_ack high before boot_done");
			end
			// A host cycle completes when its ack first shows up
			if (host_ack && !ack_seen) begin
				checks++;
				if (!host_req) begin
					report_error("host_ack with no host request");
				end else if (host_we) begin
					written[int'(host_addr)] = host_wdata;
				end else if (written.exists(int'(host_addr))) begin
					if (host_rdata !== written[int'(host_addr)]) begin
						report_mismatch("host_rdata", 32'(written[int'(host_addr)]),
							32'(host_rdata));
					end
				end else if (int'(host_addr) < `BOOT_WORDS) begin
					if (host_rdata !== image_word(int'(host_addr))) begin
						report_mismatch("host_rdata", 32'(image_word(int'(host_addr))),
							32'(host_rdata));
					end
				end else begin
					report_error("host read of an address that was never written");
				end
			end
			ack_seen = host_ack;
		end
	end

endmodule

`default_nettype wire

/* dv/tb_boot_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "boot_config.svh"

module tb_boot_mem;

	localparam int n_reads = 16;
	localparam int n_writes = 16;
	localparam int host_txns = 1 + n_reads + 2 * n_writes;
	localparam int limit_cycles =
		(`BOOT_WORDS * (`FLASH_WAIT + `RAM_WAIT + 8) + 40 * host_txns) * 2;

	logic                  clk;
	logic                  reset;
	boot_pkg::flash_addr_t flash_addr;
	boot_pkg::word_t       flash_rdata;
	logic                  flash_ce;
	logic                  flash_oe;
	boot_pkg::ram_addr_t   ram_addr;
	boot_pkg::word_t       ram_wdata;
	boot_pkg::word_t       ram_rdata;
	logic                  ram_en;
	logic                  ram_oe;
	logic                  ram_we;
	logic                  host_req;
	logic                  host_we;
	boot_pkg::ram_addr_t   host_addr;
	boot_pkg::word_t       host_wdata;
	logic                  host_ack;
	boot_pkg::word_t       host_rdata;
	logic [6:0]            seg_hi;
	logic [6:0]            seg_lo;
	logic                  boot_done;
	int                    checks;
	int                    errors;
	int                    write_errors;
	int                    seed = 32'he1e;
	int                    passed;
	int                    failed;
	int                    reset_errors;
	int                    early_errors;
	boot_pkg::word_t       sram [0:(1 << `RAM_AW) - 1];

	// Flash image is a pure function of the word address
	function automatic boot_pkg::word_t flash_word(input boot_pkg::flash_addr_t addr);
		logic [15:0] prod;
		prod = addr[15:0] * 16'h9e37;
		return prod ^ 16'h5a5a;
	endfunction

	// Both parts drive read data only while selected
	assign flash_rdata = (flash_ce && flash_oe) ? flash_word(flash_addr) : '0;
	assign ram_rdata = (ram_en && ram_oe) ? sram[ram_addr] : '0;

	always @(posedge clk) begin
		if (ram_en && ram_we) begin
			sram[ram_addr] <= ram_wdata;
		end
	end

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	boot_mem_top boot_mem_top_inst (.*);

	boot_checker checker_inst (.*);

	initial begin
		repeat (limit_cycles) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", limit_cycles);
		$display("TEST FAILED");
		$finish;
	end

	task automatic report_test(input int num, input string name, input int errs);
		if (errs == 0) begin
			passed++;
			$display("test %0d %s: pass", num, name);
		end else begin
			failed++;
			$display("test %0d %s: fail, %0d errors", num, name, errs);
		end
	endtask

	task automatic expect_low(input logic value, input string name);
		if (value !== 1'b0) begin
			reset_errors++;
			$display("error at %0t: %s is not low after reset", $time, name);
		end
	endtask

	// One four-phase host cycle starting on the current edge
	task automatic host_access(input logic we, input boot_pkg::ram_addr_t addr,
		input boot_pkg::word_t wdata);
		host_req <= 1'b1;
		host_we <= we;
		host_addr <= addr;
		host_wdata <= wdata;
		@(posedge clk);
		while (!host_ack) @(posedge clk);
		host_req <= 1'b0;
		@(posedge clk);
		while (host_ack) @(posedge clk);
	endtask

	initial begin
		int                  mark;
		boot_pkg::ram_addr_t wr_addr [n_writes];
		reset = 1'b1;
		host_req = 1'b0;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		passed = 0;
		failed = 0;
		reset_errors = 0;
		early_errors = 0;
		repeat (2) @(posedge clk);
		expect_low(flash_ce, "flash_ce");
		expect_low(flash_oe, "flash_oe");
		expect_low(ram_en, "ram_en");
		expect_low(ram_oe, "ram_oe");
		expect_low(ram_we, "ram_we");
		expect_low(host_ack, "host_ack");
		expect_low(boot_done, "boot_done");
		reset <= 1'b0;
		// Host read raised while the copy is still running
		host_req <= 1'b1;
		host_we <= 1'b0;
		host_addr <= boot_pkg::ram_addr_t'(5);
		@(posedge clk);
		while (!boot_done) begin
			if (host_ack) begin
				early_errors++;
				$display("error at %0t: host_ack given during boot", $time);
			end
			@(posedge clk);
		end
		@(posedge clk);
		report_test(1, "boot copy writes", write_errors);
		report_test(2, "boot_done and display", errors - write_errors);
		mark = errors;
		while (!host_ack) @(posedge clk);
		host_req <= 1'b0;
		@(posedge clk);
		while (host_ack) @(posedge clk);
		report_test(3, "host held off during boot", errors - mark + early_errors);
		mark = errors;
		for (int k = 0; k < n_reads; k++) begin
			host_access(1'b0, boot_pkg::ram_addr_t'($unsigned($random(seed)) % `BOOT_WORDS), '0);
		end
		report_test(4, "host reads of the image", errors - mark);
		mark = errors;
		for (int k = 0; k < n_writes; k++) begin
			wr_addr[k] = boot_pkg::ram_addr_t'($unsigned($random(seed)));
			host_access(1'b1, wr_addr[k], boot_pkg::word_t'($unsigned($random(seed))));
		end
		for (int k = n_writes - 1; k >= 0; k--) begin
			host_access(1'b0, wr_addr[k], '0);
		end
		report_test(5, "host write and read back", errors - mark + reset_errors);
		$display("summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
			passed + failed, passed, failed, checks, errors + reset_errors + early_errors);
		if (failed == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* include/boot_config.svh */
`ifndef BOOT_CONFIG_SVH
`define BOOT_CONFIG_SVH

// Program image length in 16-bit words
`define BOOT_WORDS 64

// Extra cycles a flash read needs before data is valid
`define FLASH_WAIT 3

// Extra cycles per SRAM access
`define RAM_WAIT 1

// Word address widths
`define FLASH_AW 22
`define RAM_AW 18

`endif

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_boot_mem -f build.f

output=$(./obj_dir/Vtb_boot_mem 2>&1) || true
echo "$output"

echo "$output" | grep -q "TEST OK"

/* source/boot_copier.sv */
`timescale 1ns/1ps
`default_nettype none

`include "boot_config.svh"

module boot_copier (
	input  logic                clk,
	input  logic                reset,
	mem_req_if.master           flash_ch,
	mem_req_if.master           boot_ch,
	output logic                boot_done,
	output boot_pkg::ram_addr_t copy_addr
);

	localparam int last_word = `BOOT_WORDS - 1;

	boot_pkg::copy_state_t state;
	boot_pkg::flash_addr_t fetch_idx;
	boot_pkg::word_t       word_buf;
	logic                  buf_full;
	logic                  fetch_start;
	logic                  fetch_end;
	logic                  store_start;

	// Flash side never writes, SRAM side never reads
	assign flash_ch.we = 1'b0;
	assign flash_ch.wdata = '0;
	assign boot_ch.we = 1'b1;
	assign boot_ch.addr = copy_addr;

	assign fetch_start = !flash_ch.req && !flash_ch.ack && state != boot_pkg::copy_idle
		&& fetch_idx < boot_pkg::flash_addr_t'(`BOOT_WORDS);
	// Word is held in the ack phase until the buffer is free
	assign fetch_end = flash_ch.req && flash_ch.ack && !buf_full;
	assign store_start = state == boot_pkg::copy_fetch && buf_full;

	// Fetch side runs ahead of the store by one word
	always_ff @(posedge clk) begin
		if (reset) begin
			flash_ch.req <= 1'b0;
			fetch_idx <= '0;
			buf_full <= 1'b0;
		end else begin
			if (fetch_start) begin
				flash_ch.req <= 1'b1;
				fetch_idx <= fetch_idx + 1'b1;
			end else if (fetch_end) begin
				flash_ch.req <= 1'b0;
			end
			if (fetch_end) begin
				buf_full <= 1'b1;
			end else if (store_start) begin
				buf_full <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_start) begin
			flash_ch.addr <= fetch_idx;
		end
		if (fetch_end) begin
			word_buf <= flash_ch.rdata;
		end
		if (store_start) begin
			boot_ch.wdata <= word_buf;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= boot_pkg::copy_idle;
			copy_addr <= '0;
			boot_ch.req <= 1'b0;
			boot_done <= 1'b0;
		end else begin
			case (state)
				boot_pkg::copy_idle: begin
					state <= boot_pkg::copy_fetch;
				end
				boot_pkg::copy_fetch: begin
					if (buf_full) begin
						boot_ch.req <= 1'b1;
						state <= boot_pkg::copy_store;
					end
				end
				boot_pkg::copy_store: begin
					if (boot_ch.req && boot_ch.ack) begin
						boot_ch.req <= 1'b0;
					end else if (!boot_ch.req && !boot_ch.ack) begin
						// Store cycle closed
						if (copy_addr == boot_pkg::ram_addr_t'(last_word)) begin
							boot_done <= 1'b1;
							state <= boot_pkg::copy_done;
						end else begin
							copy_addr <= copy_addr + 1'b1;
							state <= boot_pkg::copy_fetch;
						end
					end
				end
				boot_pkg::copy_done: begin
					boot_done <= 1'b1;
				end
				default: begin
					state <= boot_pkg::copy_idle;
				end
			endcase
		end
	end

	addr_in_image: assert property (
		@(posedge clk) disable iff (reset)
		copy_addr <= boot_pkg::ram_addr_t'(last_word)
	) else $error("boot_copier: copy address ran past the image");

endmodule

`default_nettype wire

/* source/boot_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "boot_config.svh"

module boot_mem_top (
	input  logic                  clk,
	input  logic                  reset,
	output boot_pkg::flash_addr_t flash_addr,
	input  boot_pkg::word_t       flash_rdata,
	output logic                  flash_ce,
	output logic                  flash_oe,
	output boot_pkg::ram_addr_t   ram_addr,
	output boot_pkg::word_t       ram_wdata,
	input  boot_pkg::word_t       ram_rdata,
	output logic                  ram_en,
	output logic                  ram_oe,
	output logic                  ram_we,
	input  logic                  host_req,
	input  logic                  host_we,
	input  boot_pkg::ram_addr_t   host_addr,
	input  boot_pkg::word_t       host_wdata,
	output logic                  host_ack,
	output boot_pkg::word_t       host_rdata,
	output logic [6:0]            seg_hi,
	output logic [6:0]            seg_lo,
	output logic                  boot_done
);

	boot_pkg::ram_addr_t copy_addr;

	mem_req_if #(.addr_w(`FLASH_AW)) flash_ch ();
	mem_req_if #(.addr_w(`RAM_AW)) boot_ch ();

	flash_reader flash_reader_inst (
		.clk(clk),
		.reset(reset),
		.flash_ch(flash_ch.slave),
		.flash_addr(flash_addr),
		.flash_rdata(flash_rdata),
		.flash_ce(flash_ce),
		.flash_oe(flash_oe)
	);

	boot_copier boot_copier_inst (
		.clk(clk),
		.reset(reset),
		.flash_ch(flash_ch.master),
		.boot_ch(boot_ch.master),
		.boot_done(boot_done),
		.copy_addr(copy_addr)
	);

	// SRAM goes to the host once boot_done is up
	ram_port ram_port_inst (
		.clk(clk),
		.reset(reset),
		.boot_ch(boot_ch.slave),
		.boot_done(boot_done),
		.host_req(host_req),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_ack(host_ack),
		.host_rdata(host_rdata),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.ram_rdata(ram_rdata),
		.ram_en(ram_en),
		.ram_oe(ram_oe),
		.ram_we(ram_we)
	);

	// Low byte of the copy address on the two digits
	seg_decoder seg_hi_inst (
		.nibble(copy_addr[7:4]),
		.seg(seg_hi)
	);

	seg_decoder seg_lo_inst (
		.nibble(copy_addr[3:0]),
		.seg(seg_lo)
	);

endmodule

`default_nettype wire

/* source/boot_pkg.sv */
`default_nettype none

`include "boot_config.svh"

package boot_pkg;

	typedef logic [15:0] word_t;

	typedef logic [`FLASH_AW-1:0] flash_addr_t;

	typedef logic [`RAM_AW-1:0] ram_addr_t;

	// Store side of the copier
	typedef enum logic [1:0] {
		copy_idle,
		copy_fetch,
		copy_store,
		copy_done
	} copy_state_t;

	typedef enum logic {
		owner_boot,
		owner_host
	} ram_owner_t;

endpackage

`default_nettype wire

/* source/flash_reader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "boot_config.svh"

module flash_reader (
	input  logic                  clk,
	input  logic                  reset,
	mem_req_if.slave              flash_ch,
	output boot_pkg::flash_addr_t flash_addr,
	input  boot_pkg::word_t       flash_rdata,
	output logic                  flash_ce,
	output logic                  flash_oe
);

	localparam int cnt_w = $clog2(`FLASH_WAIT + 1) + 1;

	logic [cnt_w-1:0] wait_cnt;
	logic             busy;
	logic             accept;
	logic             last_wait;

	assign accept = !busy && !flash_ch.ack && flash_ch.req;
	assign last_wait = busy && wait_cnt == cnt_w'(`FLASH_WAIT);

	// Chip stays selected for the whole read
	assign flash_ce = busy;
	assign flash_oe = busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			wait_cnt <= '0;
			flash_ch.ack <= 1'b0;
		end else if (accept) begin
			busy <= 1'b1;
			wait_cnt <= '0;
		end else if (last_wait) begin
			busy <= 1'b0;
			flash_ch.ack <= 1'b1;
		end else if (busy) begin
			wait_cnt <= wait_cnt + 1'b1;
		end else if (flash_ch.ack && !flash_ch.req) begin
			// Master has taken the word
			flash_ch.ack <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			flash_addr <= flash_ch.addr;
		end
		if (last_wait) begin
			flash_ch.rdata <= flash_rdata;
		end
	end

	ack_needs_req: assert property (
		@(posedge clk) disable iff (reset)
		$rose(flash_ch.ack) |-> flash_ch.req
	) else $error("flash_reader: ack raised with no pending request");

endmodule

`default_nettype wire

/* source/mem_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "boot_config.svh"

// Four-phase req/ack channel, one transfer in flight
interface mem_req_if #(
	parameter int addr_w = `RAM_AW
);

	logic              req;
	logic              ack;
	logic              we;
	logic [addr_w-1:0] addr;
	boot_pkg::word_t   wdata;
	boot_pkg::word_t   rdata;

	modport master (
		output req,
		output we,
		output addr,
		output wdata,
		input  ack,
		input  rdata
	);

	modport slave (
		input  req,
		input  we,
		input  addr,
		input  wdata,
		output ack,
		output rdata
	);

endinterface

`default_nettype wire

/* source/ram_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "boot_config.svh"

module ram_port (
	input  logic                clk,
	input  logic                reset,
	mem_req_if.slave            boot_ch,
	input  logic                boot_done,
	input  logic                host_req,
	input  logic                host_we,
	input  boot_pkg::ram_addr_t host_addr,
	input  boot_pkg::word_t     host_wdata,
	output logic                host_ack,
	output boot_pkg::word_t     host_rdata,
	output boot_pkg::ram_addr_t ram_addr,
	output boot_pkg::word_t     ram_wdata,
	input  boot_pkg::word_t     ram_rdata,
	output logic                ram_en,
	output logic                ram_oe,
	output logic                ram_we
);

	localparam int cnt_w = $clog2(`RAM_WAIT + 1) + 1;

	boot_pkg::ram_owner_t owner;
	boot_pkg::ram_addr_t  sel_addr;
	boot_pkg::word_t      sel_wdata;
	boot_pkg::word_t      rd_data;
	logic [cnt_w-1:0]     wait_cnt;
	logic                 granted;
	logic                 active;
	logic                 acc_we;
	logic                 sel_we;
	logic                 grant_boot;
	logic                 grant_host;
	logic                 last_wait;
	logic                 owner_req;

	// Copier first; host only once boot is over
	assign grant_boot = !granted && boot_ch.req;
	assign grant_host = !granted && !boot_ch.req && boot_done && host_req;
	assign last_wait = active && wait_cnt == cnt_w'(`RAM_WAIT);
	assign owner_req = (owner == boot_pkg::owner_boot) ? boot_ch.req : host_req;

	assign sel_we = grant_boot ? boot_ch.we : host_we;
	assign sel_addr = grant_boot ? boot_ch.addr : host_addr;
	assign sel_wdata = grant_boot ? boot_ch.wdata : host_wdata;

	assign boot_ch.rdata = rd_data;
	assign host_rdata = rd_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			owner <= boot_pkg::owner_boot;
			granted <= 1'b0;
			active <= 1'b0;
			wait_cnt <= '0;
			ram_en <= 1'b0;
			ram_oe <= 1'b0;
			ram_we <= 1'b0;
			boot_ch.ack <= 1'b0;
			host_ack <= 1'b0;
		end else if (grant_boot || grant_host) begin
			owner <= grant_boot ? boot_pkg::owner_boot : boot_pkg::owner_host;
			granted <= 1'b1;
			active <= 1'b1;
			wait_cnt <= '0;
			ram_en <= 1'b1;
			ram_oe <= !sel_we;
			ram_we <= sel_we && (`RAM_WAIT == 0);
		end else if (last_wait) begin
			active <= 1'b0;
			ram_en <= 1'b0;
			ram_oe <= 1'b0;
			ram_we <= 1'b0;
			if (owner == boot_pkg::owner_boot) begin
				boot_ch.ack <= 1'b1;
			end else begin
				host_ack <= 1'b1;
			end
		end else if (active) begin
			wait_cnt <= wait_cnt + 1'b1;
			// Write strobe only in the last cycle, address already settled
			ram_we <= acc_we && (wait_cnt + 1'b1 == cnt_w'(`RAM_WAIT));
		end else if (granted && !owner_req) begin
			granted <= 1'b0;
			boot_ch.ack <= 1'b0;
			host_ack <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (grant_boot || grant_host) begin
			ram_addr <= sel_addr;
			ram_wdata <= sel_wdata;
			acc_we <= sel_we;
		end
		if (last_wait && !acc_we) begin
			rd_data <= ram_rdata;
		end
	end

	no_we_with_oe: assert property (
		@(posedge clk) disable iff (reset)
		!(ram_we && ram_oe)
	) else $error("ram_port: ram_we and ram_oe high together");

	host_after_boot: assert property (
		@(posedge clk) disable iff (reset)
		host_ack |-> boot_done
	) else $error("ram_port: host served before boot finished");

endmodule

`default_nettype wire

/* source/seg_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

// Bit 0 is segment a, bit 6 is segment g
module seg_decoder (
	input  logic [3:0] nibble,
	output logic [6:0] seg
);

	always_comb begin
		case (nibble)
			4'h0: seg = 7'b0111111;
			4'h1: seg = 7'b0000110;
			4'h2: seg = 7'b1011011;
			4'h3: seg = 7'b1001111;
			4'h4: seg = 7'b1100110;
			4'h5: seg = 7'b1101101;
			4'h6: seg = 7'b1111101;
			4'h7: seg = 7'b0000111;
			4'h8: seg = 7'b1111111;
			4'h9: seg = 7'b1101111;
			4'ha: seg = 7'b1110111;
			4'hb: seg = 7'b1111100;
			4'hc: seg = 7'b0111001;
			4'hd: seg = 7'b1011110;
			4'he: seg = 7'b1111001;
			default: seg = 7'b1110001;
		endcase
	end

endmodule

`default_nettype wire
